// ==== verilog/sb_mem_pkg.sv ====
package sb_mem_pkg;

    // --------------------------------------------------
    // memory side widths
    // --------------------------------------------------

    // physical address of a store
    localparam int PLEN = 56;
    // store data width, one doubleword
    localparam int XLEN = 64;
    // one enable bit per data byte
    localparam int BE_W = XLEN / 8;
    // size code of the access
    localparam int SIZE_W = 2;
    // page offset is the same in virtual and physical space
    localparam int PAGE_OFFSET_W = 12;
    // byte position inside a doubleword is not compared
    localparam int OFFSET_CMP_LSB = 3;

    typedef logic [PLEN-1:0]          paddr_t;
    typedef logic [XLEN-1:0]          sdata_t;
    typedef logic [BE_W-1:0]          be_t;
    typedef logic [SIZE_W-1:0]        dsize_t;
    typedef logic [PAGE_OFFSET_W-1:0] page_offset_t;

    // doubleword granular page offset compare
    function automatic logic offset_match(page_offset_t offset, paddr_t addr);
        return offset[PAGE_OFFSET_W-1:OFFSET_CMP_LSB] == addr[PAGE_OFFSET_W-1:OFFSET_CMP_LSB];
    endfunction

endpackage

// ==== verilog/sb_queue_pkg.sv ====
package sb_queue_pkg;

    // --------------------------------------------------
    // queue geometry
    // --------------------------------------------------

    // stores still waiting for commit
    localparam int DEPTH_SPEC = 4;
    // committed stores waiting for memory
    localparam int DEPTH_COMMIT = 8;

    // pointers wrap naturally, depths are powers of two
    typedef logic [$clog2(DEPTH_SPEC)-1:0]   spec_ptr_t;
    // one extra bit so a full queue can be counted
    typedef logic [$clog2(DEPTH_SPEC):0]     spec_cnt_t;

    typedef logic [$clog2(DEPTH_COMMIT)-1:0] commit_ptr_t;
    typedef logic [$clog2(DEPTH_COMMIT):0]   commit_cnt_t;

    // --------------------------------------------------
    // one buffered store
    // --------------------------------------------------

    typedef struct packed {
        sb_mem_pkg::paddr_t address;
        sb_mem_pkg::sdata_t data;
        sb_mem_pkg::be_t    be;
        sb_mem_pkg::dsize_t data_size;
        // entry holds a live store
        // the offset checker looks at this bit
        logic               valid;
    } store_entry_t;

endpackage

// ==== verilog/sb_entry_if.sv ====
interface sb_entry_if;

    // head store of the speculative queue
    // no handshake, sampled only while commit is high
    sb_mem_pkg::paddr_t addr;
    sb_mem_pkg::sdata_t data;
    sb_mem_pkg::be_t    be;
    sb_mem_pkg::dsize_t size;

    // speculative side presents its oldest entry
    modport source (
        output addr,
        output data,
        output be,
        output size
    );

    // commit side copies it on commit
    modport sink (
        input addr,
        input data,
        input be,
        input size
    );

endinterface

// ==== verilog/sb_spec_queue.sv ====
module sb_spec_queue (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     valid_i,
    input  logic                     valid_no_flush_i,
    input  logic                     commit_i,
    input  logic                     flush_i,
    input  sb_mem_pkg::paddr_t       paddr_i,
    input  sb_mem_pkg::sdata_t       data_i,
    input  sb_mem_pkg::be_t          be_i,
    input  sb_mem_pkg::dsize_t       data_size_i,
    input  sb_mem_pkg::page_offset_t page_offset_i,
    sb_entry_if.source               head,
    output logic                     ready_o,
    output logic                     spec_empty_o,
    output logic                     offset_hit_o
);

    sb_queue_pkg::store_entry_t spec_q [sb_queue_pkg::DEPTH_SPEC];
    sb_queue_pkg::store_entry_t spec_n [sb_queue_pkg::DEPTH_SPEC];
    sb_queue_pkg::spec_ptr_t    rd_ptr_q, rd_ptr_n;
    sb_queue_pkg::spec_ptr_t    wr_ptr_q, wr_ptr_n;
    sb_queue_pkg::spec_cnt_t    cnt_q, cnt_n;

    // --------------------------------------------------
    // status
    // --------------------------------------------------

    // one slot is kept back unless a commit frees the head this cycle
    assign ready_o = (cnt_q < sb_queue_pkg::spec_cnt_t'(sb_queue_pkg::DEPTH_SPEC - 1)) || commit_i;
    assign spec_empty_o = (cnt_q == '0);

    // oldest store goes to the commit queue
    assign head.addr = spec_q[rd_ptr_q].address;
    assign head.data = spec_q[rd_ptr_q].data;
    assign head.be   = spec_q[rd_ptr_q].be;
    assign head.size = spec_q[rd_ptr_q].data_size;

    // --------------------------------------------------
    // push, commit and flush
    // --------------------------------------------------

    always_comb begin
        spec_n   = spec_q;
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;

        // new store from the LSU
        if (valid_i) begin
            spec_n[wr_ptr_q].address   = paddr_i;
            spec_n[wr_ptr_q].data      = data_i;
            spec_n[wr_ptr_q].be        = be_i;
            spec_n[wr_ptr_q].data_size = data_size_i;
            spec_n[wr_ptr_q].valid     = 1'b1;
            wr_ptr_n = wr_ptr_q + 1'b1;
            cnt_n    = cnt_n + 1'b1;
        end

        // head leaves for the commit queue
        if (commit_i) begin
            spec_n[rd_ptr_q].valid = 1'b0;
            rd_ptr_n = rd_ptr_q + 1'b1;
            cnt_n    = cnt_n - 1'b1;
        end

        // drop every speculative store
        if (flush_i) begin
            for (int i = 0; i < sb_queue_pkg::DEPTH_SPEC; i++) begin
                spec_n[i].valid = 1'b0;
            end
            wr_ptr_n = rd_ptr_q;
            cnt_n    = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            spec_q   <= '{default: '0};
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            spec_q   <= spec_n;
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // --------------------------------------------------
    // page offset check
    // --------------------------------------------------

    always_comb begin
        offset_hit_o = 1'b0;
        for (int i = 0; i < sb_queue_pkg::DEPTH_SPEC; i++) begin
            if (spec_q[i].valid && sb_mem_pkg::offset_match(page_offset_i, spec_q[i].address)) begin
                offset_hit_o = 1'b1;
            end
        end
        // store being placed right now
        if (valid_no_flush_i && sb_mem_pkg::offset_match(page_offset_i, paddr_i)) begin
            offset_hit_o = 1'b1;
        end
    end

    // --------------------------------------------------
    // caller rules
    // --------------------------------------------------

    // commit and flush come from the same stage and exclude each other
    a_commit_and_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !commit_i)
        else $error("speculative queue: commit and flush in the same cycle");

    a_spec_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cnt_q == sb_queue_pkg::spec_cnt_t'(sb_queue_pkg::DEPTH_SPEC)) |-> !valid_i)
        else $error("speculative queue: push while full");

    // the commit queue copies the head, so it must hold a real store
    a_spec_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cnt_q == '0) |-> !commit_i)
        else $error("speculative queue: commit while empty");

endmodule

// ==== verilog/sb_commit_queue.sv ====
module sb_commit_queue (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     commit_i,
    sb_entry_if.sink                 head,
    input  sb_mem_pkg::page_offset_t page_offset_i,
    input  logic                     mem_gnt_i,
    output logic                     mem_req_o,
    output sb_mem_pkg::paddr_t       mem_addr_o,
    output sb_mem_pkg::sdata_t       mem_wdata_o,
    output sb_mem_pkg::be_t          mem_be_o,
    output sb_mem_pkg::dsize_t       mem_size_o,
    output logic                     commit_ready_o,
    output logic                     no_st_pending_o,
    output logic                     offset_hit_o
);

    sb_queue_pkg::store_entry_t commit_q [sb_queue_pkg::DEPTH_COMMIT];
    sb_queue_pkg::store_entry_t commit_n [sb_queue_pkg::DEPTH_COMMIT];
    sb_queue_pkg::commit_ptr_t  rd_ptr_q, rd_ptr_n;
    sb_queue_pkg::commit_ptr_t  wr_ptr_q, wr_ptr_n;
    sb_queue_pkg::commit_cnt_t  cnt_q, cnt_n;

    // --------------------------------------------------
    // memory request port
    // --------------------------------------------------

    // a valid head is always requested, no longer speculative
    assign mem_req_o   = commit_q[rd_ptr_q].valid;
    assign mem_addr_o  = commit_q[rd_ptr_q].address;
    assign mem_wdata_o = commit_q[rd_ptr_q].data;
    assign mem_be_o    = commit_q[rd_ptr_q].be;
    assign mem_size_o  = commit_q[rd_ptr_q].data_size;

    assign commit_ready_o  = (cnt_q < sb_queue_pkg::commit_cnt_t'(sb_queue_pkg::DEPTH_COMMIT));
    // nothing left to write to memory
    assign no_st_pending_o = (cnt_q == '0);

    // --------------------------------------------------
    // retire on grant, fill on commit
    // --------------------------------------------------

    always_comb begin
        commit_n = commit_q;
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;

        // grant means the store is done
        // no response is awaited
        if (mem_req_o && mem_gnt_i) begin
            commit_n[rd_ptr_q].valid = 1'b0;
            rd_ptr_n = rd_ptr_q + 1'b1;
            cnt_n    = cnt_n - 1'b1;
        end

        // take over the speculative head
        if (commit_i) begin
            commit_n[wr_ptr_q].address   = head.addr;
            commit_n[wr_ptr_q].data      = head.data;
            commit_n[wr_ptr_q].be        = head.be;
            commit_n[wr_ptr_q].data_size = head.size;
            commit_n[wr_ptr_q].valid     = 1'b1;
            wr_ptr_n = wr_ptr_q + 1'b1;
            cnt_n    = cnt_n + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_q <= '{default: '0};
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            commit_q <= commit_n;
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // --------------------------------------------------
    // page offset check
    // --------------------------------------------------

    always_comb begin
        offset_hit_o = 1'b0;
        for (int i = 0; i < sb_queue_pkg::DEPTH_COMMIT; i++) begin
            if (commit_q[i].valid && sb_mem_pkg::offset_match(page_offset_i, commit_q[i].address)) begin
                offset_hit_o = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    a_commit_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cnt_q == sb_queue_pkg::commit_cnt_t'(sb_queue_pkg::DEPTH_COMMIT)) |-> !commit_i)
        else $error("commit queue: commit while full");

    // a pending request may not change until it is granted
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o)
            && $stable(mem_wdata_o) && $stable(mem_be_o) && $stable(mem_size_o)))
        else $error("commit queue: request changed before grant");

endmodule

// ==== verilog/store_buffer.sv ====
module store_buffer (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     commit_i,
    input  logic                     valid_i,
    input  logic                     valid_without_flush_i,
    input  sb_mem_pkg::paddr_t       paddr_i,
    input  sb_mem_pkg::sdata_t       data_i,
    input  sb_mem_pkg::be_t          be_i,
    input  sb_mem_pkg::dsize_t       data_size_i,
    input  sb_mem_pkg::page_offset_t page_offset_i,
    input  logic                     mem_gnt_i,
    output logic                     mem_req_o,
    output sb_mem_pkg::paddr_t       mem_addr_o,
    output sb_mem_pkg::sdata_t       mem_wdata_o,
    output sb_mem_pkg::be_t          mem_be_o,
    output sb_mem_pkg::dsize_t       mem_size_o,
    output logic                     no_st_pending_o,
    output logic                     store_buffer_empty_o,
    output logic                     page_offset_matches_o,
    output logic                     ready_o,
    output logic                     commit_ready_o
);

    logic spec_empty;
    logic spec_hit;
    logic commit_hit;

    // head entry handed over on commit
    sb_entry_if head_if ();

    // stores that may still be flushed
    sb_spec_queue i_spec_queue (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .valid_i          (valid_i),
        .valid_no_flush_i (valid_without_flush_i),
        .commit_i         (commit_i),
        .flush_i          (flush_i),
        .paddr_i          (paddr_i),
        .data_i           (data_i),
        .be_i             (be_i),
        .data_size_i      (data_size_i),
        .page_offset_i    (page_offset_i),
        .head             (head_if.source),
        .ready_o          (ready_o),
        .spec_empty_o     (spec_empty),
        .offset_hit_o     (spec_hit)
    );

    // stores that will reach memory no matter what
    sb_commit_queue i_commit_queue (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .commit_i        (commit_i),
        .head            (head_if.sink),
        .page_offset_i   (page_offset_i),
        .mem_gnt_i       (mem_gnt_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_be_o        (mem_be_o),
        .mem_size_o      (mem_size_o),
        .commit_ready_o  (commit_ready_o),
        .no_st_pending_o (no_st_pending_o),
        .offset_hit_o    (commit_hit)
    );

    // a load waits if either queue may hold an older store to its doubleword
    assign page_offset_matches_o = spec_hit | commit_hit;
    assign store_buffer_empty_o  = spec_empty & no_st_pending_o;

endmodule

// ==== bench/tb_clk_rst.sv ====
module tb_clk_rst (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 2;

    // free running clock, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
    end

    // release just after an edge so nothing samples it mid step
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;
        rst_no = 1'b1;
    end

endmodule

// ==== bench/tb_store_buffer.sv ====
module tb_store_buffer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 20;
    localparam int SEED           = 14634;
    localparam int PHASE_A_CYCLES = 400;
    localparam int FILL_LIMIT     = 40;
    localparam int DRAIN_LIMIT    = 40;
    localparam int TAIL_CYCLES    = 4;
    localparam int STIM_CYCLES    = PHASE_A_CYCLES + FILL_LIMIT + sb_queue_pkg::DEPTH_SPEC
                                    + DRAIN_LIMIT + TAIL_CYCLES + 4;
    localparam int WATCHDOG_NS    = STIM_CYCLES * CLK_PERIOD * 4;

    // model entry holding one store as the LSU handed it over
    typedef struct packed {
        sb_mem_pkg::paddr_t addr;
        sb_mem_pkg::sdata_t data;
        sb_mem_pkg::be_t    be;
        sb_mem_pkg::dsize_t size;
    } store_t;

    logic clk;
    logic rst_n;
    logic flush, commit, valid, valid_wo_flush, mem_gnt;
    sb_mem_pkg::paddr_t       paddr;
    sb_mem_pkg::sdata_t       wdata;
    sb_mem_pkg::be_t          be;
    sb_mem_pkg::dsize_t       dsize;
    sb_mem_pkg::page_offset_t page_offset;
    logic mem_req_o, no_st_pending_o, store_buffer_empty_o;
    logic page_offset_matches_o, ready_o, commit_ready_o;
    sb_mem_pkg::paddr_t mem_addr_o;
    sb_mem_pkg::sdata_t mem_wdata_o;
    sb_mem_pkg::be_t    mem_be_o;
    sb_mem_pkg::dsize_t mem_size_o;

    store_t spec_model[$];
    store_t commit_model[$];
    int check_cnt, err_cnt, push_cnt, commit_cnt, retire_cnt, flushed_cnt;
    int tries;

    tb_clk_rst i_clk_rst (.clk_o(clk), .rst_no(rst_n));

    store_buffer i_dut (
        .clk_i (clk), .rst_ni (rst_n),
        .flush_i (flush), .commit_i (commit), .valid_i (valid),
        .valid_without_flush_i (valid_wo_flush),
        .paddr_i (paddr), .data_i (wdata), .be_i (be), .data_size_i (dsize),
        .page_offset_i (page_offset), .mem_gnt_i (mem_gnt),
        .mem_req_o (mem_req_o), .mem_addr_o (mem_addr_o), .mem_wdata_o (mem_wdata_o),
        .mem_be_o (mem_be_o), .mem_size_o (mem_size_o),
        .no_st_pending_o (no_st_pending_o), .store_buffer_empty_o (store_buffer_empty_o),
        .page_offset_matches_o (page_offset_matches_o),
        .ready_o (ready_o), .commit_ready_o (commit_ready_o)
    );

    // --------------------------------------------------
    // reference model and checks
    // --------------------------------------------------

    // doubleword granular compare on bits 11 to 3 only
    function automatic logic exp_offset_match(sb_mem_pkg::page_offset_t off, logic in_valid,
                                              sb_mem_pkg::paddr_t in_addr);
        logic hit;
        hit = in_valid && (in_addr[11:3] == off[11:3]);
        foreach (spec_model[i]) begin
            if (spec_model[i].addr[11:3] == off[11:3]) begin
                hit = 1'b1;
            end
        end
        foreach (commit_model[i]) begin
            if (commit_model[i].addr[11:3] == off[11:3]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("ERROR %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_outputs();
        logic has_head;
        has_head = commit_model.size() > 0;
        compare_value("mem_req_o", 64'(has_head), 64'(mem_req_o));
        // head of the commit model is what memory must see
        if (has_head) begin
            compare_value("mem_addr_o", 64'(commit_model[0].addr), 64'(mem_addr_o));
            compare_value("mem_wdata_o", commit_model[0].data, mem_wdata_o);
            compare_value("mem_be_o", 64'(commit_model[0].be), 64'(mem_be_o));
            compare_value("mem_size_o", 64'(commit_model[0].size), 64'(mem_size_o));
        end
        compare_value("ready_o",
            64'((spec_model.size() < sb_queue_pkg::DEPTH_SPEC - 1) || commit), 64'(ready_o));
        compare_value("commit_ready_o",
            64'(commit_model.size() < sb_queue_pkg::DEPTH_COMMIT), 64'(commit_ready_o));
        compare_value("no_st_pending_o", 64'(commit_model.size() == 0), 64'(no_st_pending_o));
        compare_value("store_buffer_empty_o",
            64'(spec_model.size() == 0 && commit_model.size() == 0), 64'(store_buffer_empty_o));
        compare_value("page_offset_matches_o",
            64'(exp_offset_match(page_offset, valid_wo_flush, paddr)),
            64'(page_offset_matches_o));
    endtask

    // model state as it will be right after the coming edge
    task automatic update_model();
        store_t st;
        if (commit_model.size() > 0 && mem_gnt) begin
            st = commit_model.pop_front();
        end
        if (commit) begin
            st = spec_model.pop_front();
            commit_model.push_back(st);
            commit_cnt++;
        end
        if (valid) begin
            st.addr = paddr;
            st.data = wdata;
            st.be   = be;
            st.size = dsize;
            spec_model.push_back(st);
            push_cnt++;
        end
        if (flush) begin
            flushed_cnt += spec_model.size();
            spec_model.delete();
        end
    endtask

    // outputs settle by mid cycle and inputs hold until 2 ns after the next edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_outputs();
            // each handshake on the memory port retires one store
            if (mem_req_o && mem_gnt) begin
                retire_cnt++;
            end
            update_model();
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic drive_cycle(input int push_pct, input int commit_pct,
                               input int flush_pct, input int gnt_pct);
        logic do_flush, do_commit, do_push;
        int mode;
        int idx;
        @(posedge clk);
        #2;
        do_flush  = int'($urandom_range(99)) < flush_pct;
        // only legal commits and pushes since the DUT asserts on the rest
        do_commit = !do_flush && spec_model.size() > 0
                    && commit_model.size() < sb_queue_pkg::DEPTH_COMMIT
                    && int'($urandom_range(99)) < commit_pct;
        do_push   = !do_flush && (spec_model.size() < sb_queue_pkg::DEPTH_SPEC - 1 || do_commit)
                    && int'($urandom_range(99)) < push_pct;
        flush  = do_flush;
        commit = do_commit;
        valid  = do_push;
        // a store killed by the flush still counts for the incoming check
        valid_wo_flush = do_push || (do_flush && 1'($urandom()));
        paddr  = sb_mem_pkg::paddr_t'({$urandom(), $urandom()});
        wdata  = {$urandom(), $urandom()};
        be     = sb_mem_pkg::be_t'($urandom());
        dsize  = sb_mem_pkg::dsize_t'($urandom());
        mem_gnt = int'($urandom_range(99)) < gnt_pct;
        // aim the load at either queue, the incoming store or nowhere
        mode = int'($urandom_range(3));
        page_offset = sb_mem_pkg::page_offset_t'($urandom());
        if (mode == 0 && spec_model.size() > 0) begin
            idx = int'($urandom_range(spec_model.size() - 1));
            page_offset = spec_model[idx].addr[11:0];
        end else if (mode == 1 && commit_model.size() > 0) begin
            idx = int'($urandom_range(commit_model.size() - 1));
            page_offset = commit_model[idx].addr[11:0];
        end else if (mode == 2) begin
            page_offset = paddr[11:0];
        end
        // near miss where the byte position differs but still matches
        page_offset[2:0] = 3'($urandom());
    endtask

    initial begin
        flush = 1'b0;
        commit = 1'b0;
        valid = 1'b0;
        valid_wo_flush = 1'b0;
        mem_gnt = 1'b0;
        paddr = '0;
        wdata = '0;
        be = '0;
        dsize = '0;
        page_offset = '0;
        check_cnt = 0;
        err_cnt = 0;
        push_cnt = 0;
        commit_cnt = 0;
        retire_cnt = 0;
        flushed_cnt = 0;
        void'($urandom(SEED));
        wait (rst_n);

        // mixed traffic with random grant and rare flushes
        repeat (PHASE_A_CYCLES) drive_cycle(60, 50, 3, 50);

        // grant held low until the commit queue is full
        tries = 0;
        while (commit_model.size() < sb_queue_pkg::DEPTH_COMMIT && tries < FILL_LIMIT) begin
            drive_cycle(80, 90, 0, 0);
            tries++;
        end
        drive_cycle(0, 0, 0, 0);
        if (commit_model.size() != sb_queue_pkg::DEPTH_COMMIT) begin
            err_cnt++;
            $display("commit queue never filled while grant was held low");
        end
        compare_value("commit_ready_o", 64'(0), 64'(commit_ready_o));

        // speculative stores pile up behind a full commit queue and get flushed
        repeat (sb_queue_pkg::DEPTH_SPEC) drive_cycle(100, 0, 0, 0);
        drive_cycle(0, 0, 100, 0);

        // committed stores must still drain
        tries = 0;
        while (!(commit_model.size() == 0 && no_st_pending_o) && tries < DRAIN_LIMIT) begin
            drive_cycle(0, 0, 0, 100);
            tries++;
        end
        if (commit_model.size() != 0 || !no_st_pending_o) begin
            err_cnt++;
            $display("commit queue did not drain with grant held high");
        end
        repeat (TAIL_CYCLES) drive_cycle(0, 0, 0, 100);
        @(negedge clk);
        #1;

        if (retire_cnt != commit_cnt) begin
            err_cnt++;
            $display("memory port retired a different number of stores than were committed");
        end
        $display("checks: %0d errors: %0d pushed: %0d committed: %0d retired: %0d flushed: %0d",
                 check_cnt, err_cnt, push_cnt, commit_cnt, retire_cnt, flushed_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // run length bound of four times the stimulus
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: stimulus did not complete within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/sb_mem_pkg.sv
verilog/sb_queue_pkg.sv
verilog/sb_entry_if.sv
verilog/sb_spec_queue.sv
verilog/sb_commit_queue.sv
verilog/store_buffer.sv
bench/tb_clk_rst.sv
bench/tb_store_buffer.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_store_buffer
FILELIST := sim.f
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(EXE) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
